//--- design/boot_rom.hex
// boot image: one 32-bit instruction word per line, hex, starting at word address 0
00000093
00000113
0ff00193
00400213
0f000293
00502023
00012303
00030463
ff9ff06f
00100393
0073a023
00000013
00000013
00000013
0000006f
00000013

//--- vlog.f
design/utils_pkg.sv
design/system_peripheral_pkg.sv
design/rom_str.sv
design/boot_rom.sv
design/harvard_bootloader.sv
design/user_imem.sv
design/peripheral_decoder.sv
design/harvard_boot_top.sv
dv/harvard_boot_sva.sv
dv/tb_harvard_boot.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the boot subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_harvard_boot -o tb_sim

# the simulator exit code is not used, the log search decides
./obj_dir/tb_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi

//--- dv/tb_harvard_boot.sv
/* boot subsystem testbench */

`timescale 1ns/1ps

module tb_harvard_boot;

  logic                                   hb_clk;
  logic                                   rst_sync;
  system_peripheral_pkg::sys_peripheral_t bus;
  logic                                   ren;
  logic                                   wen;
  logic                                   download_mode;
  system_peripheral_pkg::fetch_addr_t     fetch_addr;
  utils_pkg::word_t                       rdata;
  utils_pkg::word_t                       instruction;

  // reference images
  utils_pkg::word_t boot_img [system_peripheral_pkg::BOOT_DEPTH];
  utils_pkg::word_t user_words [system_peripheral_pkg::IMEM_DEPTH];
  string            banner = "HARVARD BOOT OK\n";

  harvard_boot_top DUT (
    .hb_clk       (hb_clk),
    .rst_sync     (rst_sync),
    .bus          (bus),
    .ren          (ren),
    .wen          (wen),
    .download_mode(download_mode),
    .fetch_addr   (fetch_addr),
    .rdata        (rdata),
    .instruction  (instruction)
  );

  initial begin
    hb_clk = 1'b0;
    forever #50 hb_clk = ~hb_clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input utils_pkg::word_t expected,
                          input utils_pkg::word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // image words past the boot ROM read as zero
  function automatic utils_pkg::word_t boot_word(input int a);
    if (a < system_peripheral_pkg::BOOT_DEPTH) begin
      return boot_img[a];
    end
    return '0;
  endfunction

  task automatic bus_write(input logic [3:0] slot, input logic [3:0] ofs,
                           input utils_pkg::word_t data);
    bus.waddr = {slot, ofs};
    bus.wdata = data;
    wen       = 1'b1;
    @(posedge hb_clk);
    #1;
    wen = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] slot, input logic [3:0] ofs,
                          output utils_pkg::word_t data);
    bus.raddr = {slot, ofs};
    ren       = 1'b1;
    @(posedge hb_clk);
    #1;
    ren  = 1'b0;
    data = rdata;
  endtask

  // one random fetch address per cycle
  task automatic check_fetch(input string name, input bit from_user, input int count);
    int fa;
    for (int i = 0; i < count; i++) begin
      fa         = $urandom_range(63, 0);
      fetch_addr = system_peripheral_pkg::fetch_addr_t'(fa);
      @(posedge hb_clk);
      #1;
      check_eq(name, from_user ? user_words[fa] : boot_word(fa), instruction);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_boot();
    utils_pkg::word_t got;
    check_eq("test_reset_boot rdata", '0, rdata);
    check_fetch("test_reset_boot fetch", 1'b0, 8);
    download_mode = 1'b1;
    bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::DEBUG_OFS, got);
    check_eq("test_reset_boot download 1", 32'd1, got);
    download_mode = 1'b0;
    bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::DEBUG_OFS, got);
    check_eq("test_reset_boot download 0", 32'd0, got);
  endtask

  task automatic test_banner();
    utils_pkg::word_t got;
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_ADDR_OFS, 32'd0);
    for (int i = 0; i < banner.len(); i++) begin
      bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_DATA_OFS, got);
      check_eq("test_banner char", {24'b0, banner[i]}, got);
    end
    bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_DATA_OFS, got);
    check_eq("test_banner past end", 32'd0, got);
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_ADDR_OFS, 32'd5);
    bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_DATA_OFS, got);
    check_eq("test_banner address 5", {24'b0, banner[5]}, got);
  endtask

  task automatic test_download();
    utils_pkg::word_t got;
    utils_pkg::word_t w;
    bus_write(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_ADDR_OFS, 32'd0);
    for (int i = 0; i < system_peripheral_pkg::IMEM_DEPTH; i++) begin
      w = $urandom();
      // user word must differ from boot word so the switch shows
      if (w == boot_word(i)) begin
        w = ~w;
      end
      user_words[i] = w;
      bus_write(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_DATA_OFS, w);
    end
    bus_write(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_ADDR_OFS, 32'd0);
    for (int i = 0; i < system_peripheral_pkg::IMEM_DEPTH; i++) begin
      bus_read(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_READ_OFS, got);
      check_eq("test_download readback", user_words[i], got);
    end
    check_fetch("test_download boot fetch", 1'b0, 8);
  endtask

  task automatic test_mode_switch();
    int fa;
    int edges;
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::DEBUG_OFS, 32'h0F);
    check_fetch("test_mode_switch non-key", 1'b0, 6);
    fa         = $urandom_range(63, 0);
    fetch_addr = system_peripheral_pkg::fetch_addr_t'(fa);
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::DEBUG_OFS,
              {24'b0, system_peripheral_pkg::BOOT_KEY});
    edges = 0;
    while (instruction !== user_words[fa]) begin
      if (edges >= 10) begin
        $display("instruction did not switch to user memory within %0d cycles", edges);
        abort_run();
      end
      @(posedge hb_clk);
      #1;
      edges++;
    end
    check_eq("test_mode_switch edges", 32'd2, edges);
    check_fetch("test_mode_switch user fetch", 1'b1, 8);
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::DEBUG_OFS, 32'd0);
    check_fetch("test_mode_switch stays", 1'b1, 6);
  endtask

  task automatic test_unmapped();
    utils_pkg::word_t got;
    bus_write(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_ADDR_OFS, 32'd3);
    bus_write(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_ADDR_OFS, 32'd7);
    bus_read(4'd5, 4'd0, got);
    check_eq("test_unmapped read", 32'd0, got);
    bus_write(4'd5, 4'd0, 32'h0000_00F0);
    bus_write(4'd5, 4'd1, 32'h0000_002A);
    bus_write(4'd5, 4'd2, 32'h1234_5678);
    bus_read(system_peripheral_pkg::SLOT_BOOT, system_peripheral_pkg::STR_DATA_OFS, got);
    check_eq("test_unmapped string", {24'b0, banner[3]}, got);
    bus_read(system_peripheral_pkg::SLOT_IMEM, system_peripheral_pkg::IMEM_READ_OFS, got);
    check_eq("test_unmapped memory", user_words[7], got);
  endtask

  initial begin
    void'($urandom(27));
    rst_sync      = 1'b1;
    bus           = '0;
    ren           = 1'b0;
    wen           = 1'b0;
    download_mode = 1'b0;
    fetch_addr    = '0;
    for (int i = 0; i < system_peripheral_pkg::BOOT_DEPTH; i++) begin
      boot_img[i] = '0;
    end
    $readmemh("design/boot_rom.hex", boot_img);
    repeat (2) @(posedge hb_clk);
    #1;
    rst_sync = 1'b0;
    test_reset_boot();
    test_banner();
    test_download();
    test_mode_switch();
    test_unmapped();
    $display("Test passed");
    $finish;
  end

endmodule

//--- dv/harvard_boot_sva.sv
/* bootloader run mode checks */

`timescale 1ns/1ps

module harvard_boot_sva (
  input                                   hb_clk,
  input                                   rst_sync,
  input system_peripheral_pkg::run_mode_e run_mode,
  input                                   w_debug,
  input utils_pkg::byte_t                 wr_byte,
  input utils_pkg::word_t                 instruction,
  input utils_pkg::word_t                 user_instruction
);

  logic key_write;

  assign key_write = w_debug && (wr_byte == system_peripheral_pkg::BOOT_KEY);

  // ~~~~~~~~~~~~~~~~~~~~
  // run mode
  // ~~~~~~~~~~~~~~~~~~~~
  mode_sticky: assert property (@(posedge hb_clk) disable iff (rst_sync)
    run_mode == system_peripheral_pkg::NORMAL |=> run_mode == system_peripheral_pkg::NORMAL)
    else $error("run mode left NORMAL without a reset");

  // key sampled at edge 0, mode visible after edge 2
  key_to_normal: assert property (@(posedge hb_clk) disable iff (rst_sync)
    $past(key_write, 3) |-> run_mode == system_peripheral_pkg::NORMAL)
    else $error("run mode not NORMAL two edges after the boot key write");

  user_source: assert property (@(posedge hb_clk) disable iff (rst_sync)
    run_mode == system_peripheral_pkg::NORMAL |-> instruction == user_instruction)
    else $error("instruction not taken from user memory in NORMAL mode");

endmodule

bind harvard_bootloader harvard_boot_sva u_boot_sva (
  .hb_clk          (hb_clk),
  .rst_sync        (rst_sync),
  .run_mode        (run_mode),
  .w_debug         (w_debug),
  .wr_byte         (sys_share.wdata[7:0]),
  .instruction     (instruction),
  .user_instruction(user_instruction)
);

//--- design/harvard_boot_top.sv
/* boot and download subsystem */

`timescale 1ns/1ps

module harvard_boot_top (
  input                                          hb_clk,
  input                                          rst_sync,
  input  system_peripheral_pkg::sys_peripheral_t bus,
  input                                          ren,
  input                                          wen,
  input                                          download_mode,
  input  system_peripheral_pkg::fetch_addr_t     fetch_addr,
  output utils_pkg::word_t                       rdata,
  output utils_pkg::word_t                       instruction
);

  utils_pkg::sel_t  boot_sel;
  utils_pkg::sel_t  imem_sel;
  utils_pkg::word_t boot_rdata;
  utils_pkg::word_t imem_rdata;
  utils_pkg::word_t boot_instruction;
  utils_pkg::word_t user_instruction;

  // ~~~~~~~~~~~~~~~~~~~~
  // bus side
  // ~~~~~~~~~~~~~~~~~~~~
  peripheral_decoder u_decoder (
    .hb_clk    (hb_clk),
    .rst_sync  (rst_sync),
    .raddr     (bus.raddr),
    .waddr     (bus.waddr),
    .ren       (ren),
    .wen       (wen),
    .boot_rdata(boot_rdata),
    .imem_rdata(imem_rdata),
    .boot_sel  (boot_sel),
    .imem_sel  (imem_sel),
    .rdata     (rdata)
  );

  // slot 0
  harvard_bootloader u_bootloader (
    .hb_clk                (hb_clk),
    .rst_sync              (rst_sync),
    .bootloader_instruction(boot_instruction),
    .user_instruction      (user_instruction),
    .sys_share             (bus),
    .sel                   (boot_sel),
    .download_mode         (download_mode),
    .instruction           (instruction),
    .rdata                 (boot_rdata)
  );

  // slot 1
  user_imem u_user_imem (
    .hb_clk     (hb_clk),
    .rst_sync   (rst_sync),
    .sys_share  (bus),
    .sel        (imem_sel),
    .fetch_addr (fetch_addr),
    .rdata      (imem_rdata),
    .instruction(user_instruction)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // fetch side
  // ~~~~~~~~~~~~~~~~~~~~
  boot_rom u_boot_rom (
    .fetch_addr (fetch_addr),
    .instruction(boot_instruction)
  );

endmodule

//--- design/peripheral_decoder.sv
/* peripheral slot decoder */

`timescale 1ns/1ps

module peripheral_decoder (
  input                                    hb_clk,
  input                                    rst_sync,
  input  system_peripheral_pkg::bus_addr_t raddr,
  input  system_peripheral_pkg::bus_addr_t waddr,
  input                                    ren,
  input                                    wen,
  input  utils_pkg::word_t                 boot_rdata,
  input  utils_pkg::word_t                 imem_rdata,
  output utils_pkg::sel_t                  boot_sel,
  output utils_pkg::sel_t                  imem_sel,
  output utils_pkg::word_t                 rdata
);

  // ~~~~~~~~~~~~~~~~~~~~
  // slot match
  // ~~~~~~~~~~~~~~~~~~~~
  logic r_boot;
  logic r_imem;
  logic w_boot;
  logic w_imem;

  assign r_boot = (raddr[7:4] == system_peripheral_pkg::SLOT_BOOT);
  assign r_imem = (raddr[7:4] == system_peripheral_pkg::SLOT_IMEM);
  assign w_boot = (waddr[7:4] == system_peripheral_pkg::SLOT_BOOT);
  assign w_imem = (waddr[7:4] == system_peripheral_pkg::SLOT_IMEM);

  assign boot_sel.ren = ren && r_boot;
  assign boot_sel.wen = wen && w_boot;
  assign imem_sel.ren = ren && r_imem;
  assign imem_sel.wen = wen && w_imem;

  // ~~~~~~~~~~~~~~~~~~~~
  // read return
  // ~~~~~~~~~~~~~~~~~~~~
  // last slot read, both clear for an unmapped slot
  logic last_boot;
  logic last_imem;

  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      last_boot <= 1'b0;
      last_imem <= 1'b0;
    end else if (ren) begin
      last_boot <= r_boot;
      last_imem <= r_imem;
    end
  end

  always_comb begin
    if (last_boot) begin
      rdata = boot_rdata;
    end else if (last_imem) begin
      rdata = imem_rdata;
    end else begin
      rdata = '0;
    end
  end

endmodule

//--- design/user_imem.sv
/* user instruction memory */

`timescale 1ns/1ps

module user_imem (
  input                                          hb_clk,
  input                                          rst_sync,
  input  system_peripheral_pkg::sys_peripheral_t sys_share,
  input  utils_pkg::sel_t                        sel,
  input  system_peripheral_pkg::fetch_addr_t     fetch_addr,
  output utils_pkg::word_t                       rdata,
  output utils_pkg::word_t                       instruction
);

  localparam int DEPTH = system_peripheral_pkg::IMEM_DEPTH;

  utils_pkg::word_t mem [DEPTH];
  system_peripheral_pkg::fetch_addr_t ptr;

  system_peripheral_pkg::bus_ofs_t r_ofs;
  system_peripheral_pkg::bus_ofs_t w_ofs;
  logic wr_ptr;
  logic wr_data;
  logic rd_data;

  assign r_ofs   = sys_share.raddr[3:0];
  assign w_ofs   = sys_share.waddr[3:0];
  assign wr_ptr  = sel.wen && (w_ofs == system_peripheral_pkg::IMEM_ADDR_OFS);
  assign wr_data = sel.wen && (w_ofs == system_peripheral_pkg::IMEM_DATA_OFS);
  assign rd_data = sel.ren && (r_ofs == system_peripheral_pkg::IMEM_READ_OFS);

  // ~~~~~~~~~~~~~~~~~~~~
  // download pointer
  // ~~~~~~~~~~~~~~~~~~~~
  // a write and a read in one cycle share the same slot
  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      ptr <= '0;
    end else if (wr_ptr) begin
      ptr <= system_peripheral_pkg::fetch_addr_t'(sys_share.wdata);
    end else if (wr_data || rd_data) begin
      ptr <= ptr + 1'b1;
    end
  end

  always_ff @(posedge hb_clk) begin
    if (wr_data) begin
      mem[ptr] <= sys_share.wdata;
    end
  end

  // bus read, pointer offset reads back the pointer
  always_ff @(posedge hb_clk) begin
    if (sel.ren) begin
      case (r_ofs)
        system_peripheral_pkg::IMEM_ADDR_OFS: rdata <= {26'b0, ptr};
        system_peripheral_pkg::IMEM_READ_OFS: rdata <= mem[ptr];
        default:                              rdata <= '0;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // fetch port
  // ~~~~~~~~~~~~~~~~~~~~
  assign instruction = mem[fetch_addr];

endmodule

//--- design/harvard_bootloader.sv
/* bootloader registers and
   instruction source select */

`timescale 1ns/1ps

module harvard_bootloader (
  input                                          hb_clk,
  input                                          rst_sync,
  input  utils_pkg::word_t                       bootloader_instruction,
  input  utils_pkg::word_t                       user_instruction,
  input  system_peripheral_pkg::sys_peripheral_t sys_share,
  input  utils_pkg::sel_t                        sel,
  input                                          download_mode,
  output utils_pkg::word_t                       instruction,
  output utils_pkg::word_t                       rdata
);

  system_peripheral_pkg::bus_ofs_t r_ofs;
  system_peripheral_pkg::bus_ofs_t w_ofs;
  logic r_str;
  logic w_debug;
  logic w_str_addr;

  assign r_ofs      = sys_share.raddr[3:0];
  assign w_ofs      = sys_share.waddr[3:0];
  assign r_str      = sel.ren && (r_ofs == system_peripheral_pkg::STR_DATA_OFS);
  assign w_debug    = sel.wen && (w_ofs == system_peripheral_pkg::DEBUG_OFS);
  assign w_str_addr = sel.wen && (w_ofs == system_peripheral_pkg::STR_ADDR_OFS);

  // ~~~~~~~~~~~~~~~~~~~~
  // banner string
  // ~~~~~~~~~~~~~~~~~~~~
  system_peripheral_pkg::str_addr_t str_addr;
  system_peripheral_pkg::str_addr_t str_addr_rd;
  utils_pkg::byte_t str_data;

  // same-cycle address write wins over the stored pointer
  assign str_addr_rd = w_str_addr ? system_peripheral_pkg::str_addr_t'(sys_share.wdata)
                                  : str_addr;

  rom_str u_rom_str (
    .address(str_addr_rd),
    .data   (str_data)
  );

  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      str_addr <= '0;
    end else if (r_str) begin
      str_addr <= str_addr_rd + 1'b1;
    end else if (w_str_addr) begin
      str_addr <= str_addr_rd;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // run mode
  // ~~~~~~~~~~~~~~~~~~~~
  utils_pkg::byte_t debug_reg;
  logic key_armed;
  system_peripheral_pkg::run_mode_e run_mode;

  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      debug_reg <= '0;
    end else if (w_debug) begin
      debug_reg <= sys_share.wdata[7:0];
    end
  end

  // extra stage gives the core time to bring pc back to zero
  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      key_armed <= 1'b0;
      run_mode  <= system_peripheral_pkg::BOOT;
    end else begin
      key_armed <= (run_mode == system_peripheral_pkg::BOOT) &&
                   (debug_reg == system_peripheral_pkg::BOOT_KEY);
      case (run_mode)
        system_peripheral_pkg::BOOT: begin
          if (key_armed) begin
            run_mode <= system_peripheral_pkg::NORMAL;
          end
        end
        default: run_mode <= system_peripheral_pkg::NORMAL;
      endcase
    end
  end

  assign instruction = (run_mode == system_peripheral_pkg::NORMAL) ? user_instruction
                                                                   : bootloader_instruction;

  // ~~~~~~~~~~~~~~~~~~~~
  // register read
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hb_clk) begin
    if (sel.ren) begin
      case (r_ofs)
        system_peripheral_pkg::DEBUG_OFS:    rdata <= {31'b0, download_mode};
        system_peripheral_pkg::STR_DATA_OFS: rdata <= {24'b0, str_data};
        default:                             rdata <= '0;
      endcase
    end
  end

endmodule

//--- design/boot_rom.sv
/* bootloader instruction ROM */

`timescale 1ns/1ps

module boot_rom (
  input  system_peripheral_pkg::fetch_addr_t fetch_addr,
  output utils_pkg::word_t                   instruction
);

  localparam int DEPTH = system_peripheral_pkg::BOOT_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // highest fetch address backed by the image
  localparam system_peripheral_pkg::fetch_addr_t LAST_ADDR =
    system_peripheral_pkg::fetch_addr_t'(DEPTH - 1);

  utils_pkg::word_t rom [DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~
  // image load
  // ~~~~~~~~~~~~~~~~~~~~
  // short image leaves the tail zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      rom[i] = '0;
    end
    $readmemh("design/boot_rom.hex", rom);
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // fetch port
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (fetch_addr <= LAST_ADDR) begin
      instruction = rom[fetch_addr[AW-1:0]];
    end else begin
      instruction = '0;
    end
  end

endmodule

//--- design/rom_str.sv
/* banner string ROM */

`timescale 1ns/1ps

module rom_str (
  input  system_peripheral_pkg::str_addr_t address,
  output utils_pkg::byte_t                 data
);

  localparam int DEPTH = system_peripheral_pkg::STR_DEPTH;
  localparam int LEN   = system_peripheral_pkg::BANNER_LEN;

  typedef logic [DEPTH*8-1:0] table_t;

  // entry i lands in byte lane i, unused entries stay zero
  function automatic table_t build_table();
    table_t t;
    t = '0;
    for (int i = 0; i < LEN; i++) begin
      t[i*8 +: 8] = system_peripheral_pkg::BANNER[(LEN-1-i)*8 +: 8];
    end
    return t;
  endfunction

  localparam table_t TABLE = build_table();

  // ~~~~~~~~~~~~~~~~~~~~
  // combinational read
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    data = TABLE[address*8 +: 8];
  end

endmodule

//--- design/system_peripheral_pkg.sv
/* peripheral bus and address map */

package system_peripheral_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // memory depths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int STR_DEPTH  = 64;
  localparam int BOOT_DEPTH = 32;
  localparam int IMEM_DEPTH = 64;

  // ~~~~~~~~~~~~~~~~~~~~
  // address types
  // ~~~~~~~~~~~~~~~~~~~~
  // upper nibble is the slot, lower nibble the register offset
  typedef logic [7:0] bus_addr_t;
  typedef logic [3:0] bus_ofs_t;
  typedef logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr_t;
  typedef logic [$clog2(STR_DEPTH)-1:0] str_addr_t;

  // shared bus seen by every slot
  typedef struct packed {
    bus_addr_t        raddr;
    bus_addr_t        waddr;
    utils_pkg::word_t wdata;
  } sys_peripheral_t;

  typedef enum logic [3:0] {
    SLOT_BOOT = 4'd0,
    SLOT_IMEM = 4'd1
  } slot_e;

  typedef enum logic {
    BOOT   = 1'b0,
    NORMAL = 1'b1
  } run_mode_e;

  // bootloader registers
  localparam bus_ofs_t DEBUG_OFS    = 4'd0;
  localparam bus_ofs_t STR_ADDR_OFS = 4'd1;
  localparam bus_ofs_t STR_DATA_OFS = 4'd2;

  // user memory registers
  localparam bus_ofs_t IMEM_ADDR_OFS = 4'd0;
  localparam bus_ofs_t IMEM_DATA_OFS = 4'd1;
  localparam bus_ofs_t IMEM_READ_OFS = 4'd2;

  // ~~~~~~~~~~~~~~~~~~~~
  // key values
  // ~~~~~~~~~~~~~~~~~~~~
  localparam utils_pkg::byte_t BOOT_KEY = 8'hF0;
  localparam int BANNER_LEN = 16;
  // first character sits in the top byte
  localparam logic [BANNER_LEN*8-1:0] BANNER = "HARVARD BOOT OK\n";

endpackage

//--- design/utils_pkg.sv
/* generic bus types */

package utils_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // data widths
  // ~~~~~~~~~~~~~~~~~~~~

  // one bus data word
  typedef logic [31:0] word_t;

  // one character or small register
  typedef logic [7:0] byte_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // per-slot select
  // ~~~~~~~~~~~~~~~~~~~~

  // enables already qualified by slot match
  typedef struct packed {
    logic ren;
    logic wen;
  } sel_t;

endpackage
